// File: Bender.yml
package:
  name: mem_check

sources:
  - design/mem_check_pkg.sv
  - design/np2_addr_split.sv
  - design/port_rule_check.sv
  - design/bit_shadow.sv
  - design/read_data_check.sv
  - design/mem_check_top.sv
  - target: simulation
    files:
      - verification/mem_check_monitor.sv
      - verification/mem_check_tb.sv

// File: design/bit_shadow.sv
`timescale 1ns/100ps
`default_nettype none

module bit_shadow import mem_check_pkg::*; #(
  parameter int SRAM_DELAY = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    write [NUMWRPT],
  input  addr_t   wr_adr [NUMWRPT],
  input  word_t   din [NUMWRPT],
  input  logic    t1_write [NUMVBNK][NUMBWR],
  input  row_t    t1_wr_row [NUMVBNK][NUMBWR],
  input  word_t   t1_din [NUMVBNK][NUMBWR],
  input  addr_t   select_addr,
  input  bitsel_t select_bit,
  input  bank_t   select_bank,
  input  row_t    select_row,
  output logic    lmem_hist,
  output logic    lmem_inv_hist,
  output logic    bmem_hist,
  output logic    bmem_inv_hist
);

  logic lmem;
  logic lmem_inv;
  logic bmem;
  logic bmem_inv;

  // {logical, bank} per stage, stage i is i+1 cycles old
  logic [1:0] mem_pipe [SRAM_DELAY];
  logic [1:0] inv_pipe [SRAM_DELAY];

  // logical view, later port overrides earlier one
  always_ff @(posedge clk) begin
    if (rst) begin
      lmem_inv <= 1'b1;
    end else begin
      for (int p = 0; p < NUMWRPT; p++) begin
        if (write[p] && (wr_adr[p] == select_addr)) begin
          lmem_inv <= 1'b0;
          lmem     <= din[p][select_bit];
        end
      end
    end
  end

  // bank view, only the bank that holds the address
  always_ff @(posedge clk) begin
    if (rst) begin
      bmem_inv <= 1'b1;
    end else begin
      for (int p = 0; p < NUMBWR; p++) begin
        if (t1_write[select_bank][p] && (t1_wr_row[select_bank][p] == select_row)) begin
          bmem_inv <= 1'b0;
          bmem     <= t1_din[select_bank][p][select_bit];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    mem_pipe[0] <= {lmem, bmem};
    for (int i = 1; i < SRAM_DELAY; i++) begin
      mem_pipe[i] <= mem_pipe[i-1];
    end
  end

  // history starts out invalid so early reads never compare
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SRAM_DELAY; i++) begin
        inv_pipe[i] <= 2'b11;
      end
    end else begin
      inv_pipe[0] <= {lmem_inv, bmem_inv};
      for (int i = 1; i < SRAM_DELAY; i++) begin
        inv_pipe[i] <= inv_pipe[i-1];
      end
    end
  end

  // value as seen SRAM_DELAY cycles back
  assign {lmem_hist, bmem_hist}         = mem_pipe[SRAM_DELAY-1];
  assign {lmem_inv_hist, bmem_inv_hist} = inv_pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

// File: design/mem_check_pkg.sv
`default_nettype none

package mem_check_pkg;

  // logical memory geometry
  localparam int WIDTH   = 16;
  localparam int NUMADDR = 96;
  localparam int BITADDR = 7;

  // banked view, bank count is not a power of two
  localparam int NUMVBNK = 3;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 32;
  localparam int BITVROW = 5;

  localparam int BITWDTH = 4;  // selects one bit of a word

  // logical ports
  localparam int NUMWRPT = 2;
  localparam int NUMRDPT = 2;

  // ports on each bank
  localparam int NUMBWR  = 2;
  localparam int NUMBRD  = 2;

  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [BITVBNK-1:0] bank_t;
  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [BITWDTH-1:0] bitsel_t;

endpackage

`default_nettype wire

// File: design/mem_check_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_check_top import mem_check_pkg::*; #(
  parameter int SRAM_DELAY = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    write [NUMWRPT],
  input  addr_t   wr_adr [NUMWRPT],
  input  word_t   din [NUMWRPT],
  input  logic    read [NUMRDPT],
  input  addr_t   rd_adr [NUMRDPT],
  input  logic    rd_vld [NUMRDPT],
  input  word_t   rd_dout [NUMRDPT],
  input  logic    t1_write [NUMVBNK][NUMBWR],
  input  row_t    t1_wr_row [NUMVBNK][NUMBWR],
  input  word_t   t1_din [NUMVBNK][NUMBWR],
  input  logic    t1_read [NUMVBNK][NUMBRD],
  input  row_t    t1_rd_row [NUMVBNK][NUMBRD],
  input  word_t   t1_dout [NUMVBNK][NUMBRD],
  input  addr_t   select_addr,  // held from reset on
  input  bitsel_t select_bit,
  output logic    err_range,
  output logic    err_conflict,
  output logic    err_rd_vld,
  output logic    err_rd_data,
  output logic    err_bank_data
);

  bank_t select_bank;
  row_t  select_row;
  logic  lmem_hist;
  logic  lmem_inv_hist;
  logic  bmem_hist;
  logic  bmem_inv_hist;

  np2_addr_split np2_addr_split_inst (
    .clk         (clk),
    .rst         (rst),
    .select_addr (select_addr),
    .select_bank (select_bank),
    .select_row  (select_row)
  );

  port_rule_check port_rule_check_inst (
    .clk          (clk),
    .rst          (rst),
    .write        (write),
    .wr_adr       (wr_adr),
    .read         (read),
    .rd_adr       (rd_adr),
    .t1_write     (t1_write),
    .t1_wr_row    (t1_wr_row),
    .err_range    (err_range),
    .err_conflict (err_conflict)
  );

  bit_shadow #(
    .SRAM_DELAY (SRAM_DELAY)
  ) bit_shadow_inst (
    .clk           (clk),
    .rst           (rst),
    .write         (write),
    .wr_adr        (wr_adr),
    .din           (din),
    .t1_write      (t1_write),
    .t1_wr_row     (t1_wr_row),
    .t1_din        (t1_din),
    .select_addr   (select_addr),
    .select_bit    (select_bit),
    .select_bank   (select_bank),
    .select_row    (select_row),
    .lmem_hist     (lmem_hist),
    .lmem_inv_hist (lmem_inv_hist),
    .bmem_hist     (bmem_hist),
    .bmem_inv_hist (bmem_inv_hist)
  );

  read_data_check #(
    .SRAM_DELAY (SRAM_DELAY)
  ) read_data_check_inst (
    .clk           (clk),
    .rst           (rst),
    .read          (read),
    .rd_adr        (rd_adr),
    .rd_vld        (rd_vld),
    .rd_dout       (rd_dout),
    .t1_read       (t1_read),
    .t1_rd_row     (t1_rd_row),
    .t1_dout       (t1_dout),
    .select_addr   (select_addr),
    .select_bit    (select_bit),
    .select_bank   (select_bank),
    .select_row    (select_row),
    .lmem_hist     (lmem_hist),
    .lmem_inv_hist (lmem_inv_hist),
    .bmem_hist     (bmem_hist),
    .bmem_inv_hist (bmem_inv_hist),
    .err_rd_vld    (err_rd_vld),
    .err_rd_data   (err_rd_data),
    .err_bank_data (err_bank_data)
  );

endmodule

`default_nettype wire

// File: design/np2_addr_split.sv
`timescale 1ns/100ps
`default_nettype none

module np2_addr_split import mem_check_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  addr_t select_addr,
  output bank_t select_bank,
  output row_t  select_row
);

  // interleaved mapping, consecutive addresses land in consecutive banks
  assign select_bank = bank_t'(select_addr % NUMVBNK);
  assign select_row  = row_t'(select_addr / NUMVBNK);  // divide by constant

  // tracked address must be a real location and stay put once running
  a_split_range: assert property (
    @(posedge clk) disable iff (rst)
    (select_addr < NUMADDR) && $stable(select_addr)
  );

endmodule

`default_nettype wire

// File: design/port_rule_check.sv
`timescale 1ns/100ps
`default_nettype none

module port_rule_check import mem_check_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  write [NUMWRPT],
  input  addr_t wr_adr [NUMWRPT],
  input  logic  read [NUMRDPT],
  input  addr_t rd_adr [NUMRDPT],
  input  logic  t1_write [NUMVBNK][NUMBWR],
  input  row_t  t1_wr_row [NUMVBNK][NUMBWR],
  output logic  err_range,
  output logic  err_conflict
);

  logic range_hit;
  logic conflict_hit;

  // address space ends at NUMADDR, top codes unused
  always_comb begin
    range_hit = 1'b0;
    for (int p = 0; p < NUMWRPT; p++) begin
      if (write[p] && (wr_adr[p] >= NUMADDR)) begin
        range_hit = 1'b1;
      end
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      if (read[p] && (rd_adr[p] >= NUMADDR)) begin
        range_hit = 1'b1;
      end
    end
  end

  // two write ports of one bank must not target the same row
  always_comb begin
    conflict_hit = 1'b0;
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int i = 0; i < NUMBWR; i++) begin
        for (int j = i + 1; j < NUMBWR; j++) begin
          if (t1_write[b][i] && t1_write[b][j] &&
              (t1_wr_row[b][i] == t1_wr_row[b][j])) begin
            conflict_hit = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_range    <= 1'b0;
      err_conflict <= 1'b0;
    end else begin
      err_range    <= range_hit;
      err_conflict <= conflict_hit;  // one cycle after the offending strobe
    end
  end

  // an x on any strobe or address would show up here
  a_flags_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown({err_range, err_conflict})
  );

endmodule

`default_nettype wire

// File: design/read_data_check.sv
`timescale 1ns/100ps
`default_nettype none

module read_data_check import mem_check_pkg::*; #(
  parameter int SRAM_DELAY = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    read [NUMRDPT],
  input  addr_t   rd_adr [NUMRDPT],
  input  logic    rd_vld [NUMRDPT],
  input  word_t   rd_dout [NUMRDPT],
  input  logic    t1_read [NUMVBNK][NUMBRD],
  input  row_t    t1_rd_row [NUMVBNK][NUMBRD],
  input  word_t   t1_dout [NUMVBNK][NUMBRD],
  input  addr_t   select_addr,
  input  bitsel_t select_bit,
  input  bank_t   select_bank,
  input  row_t    select_row,
  input  logic    lmem_hist,
  input  logic    lmem_inv_hist,
  input  logic    bmem_hist,
  input  logic    bmem_inv_hist,
  output logic    err_rd_vld,
  output logic    err_rd_data,
  output logic    err_bank_data
);

  logic sel_rd [NUMRDPT];
  logic sel_brd [NUMBRD];
  logic [SRAM_DELAY-1:0] rd_pipe [NUMRDPT];  // msb is due this cycle
  logic [SRAM_DELAY-1:0] brd_pipe [NUMBRD];
  logic vld_miss;
  logic rd_mismatch;
  logic bank_mismatch;

  always_comb begin
    for (int p = 0; p < NUMRDPT; p++) begin
      sel_rd[p] = read[p] && (rd_adr[p] == select_addr);
    end
    for (int q = 0; q < NUMBRD; q++) begin
      sel_brd[q] = t1_read[select_bank][q] && (t1_rd_row[select_bank][q] == select_row);
    end
  end

  // reads overlap, one bit per cycle in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < NUMRDPT; p++) begin
        rd_pipe[p] <= '0;
      end
      for (int q = 0; q < NUMBRD; q++) begin
        brd_pipe[q] <= '0;
      end
    end else begin
      for (int p = 0; p < NUMRDPT; p++) begin
        rd_pipe[p] <= (rd_pipe[p] << 1) | SRAM_DELAY'(sel_rd[p]);
      end
      for (int q = 0; q < NUMBRD; q++) begin
        brd_pipe[q] <= (brd_pipe[q] << 1) | SRAM_DELAY'(sel_brd[q]);
      end
    end
  end

  always_comb begin
    vld_miss      = 1'b0;
    rd_mismatch   = 1'b0;
    bank_mismatch = 1'b0;
    for (int p = 0; p < NUMRDPT; p++) begin
      if (rd_pipe[p][SRAM_DELAY-1]) begin
        if (!rd_vld[p]) begin
          vld_miss = 1'b1;
        end
        if (!lmem_inv_hist && (rd_dout[p][select_bit] != lmem_hist)) begin
          rd_mismatch = 1'b1;
        end
      end
    end
    for (int q = 0; q < NUMBRD; q++) begin
      if (brd_pipe[q][SRAM_DELAY-1] && !bmem_inv_hist &&
          (t1_dout[select_bank][q][select_bit] != bmem_hist)) begin
        bank_mismatch = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_rd_vld    <= 1'b0;
      err_rd_data   <= 1'b0;
      err_bank_data <= 1'b0;
    end else begin
      err_rd_vld    <= vld_miss;
      err_rd_data   <= rd_mismatch;
      err_bank_data <= bank_mismatch;
    end
  end

  // a selected read answered without rd_vld shows up on err_rd_vld
  for (genvar p = 0; p < NUMRDPT; p++) begin : g_vld_chk
    a_rd_vld: assert property (
      @(posedge clk) disable iff (rst)
      sel_rd[p] ##SRAM_DELAY !rd_vld[p] |=> err_rd_vld
    );
  end

endmodule

`default_nettype wire

// File: project.f
design/mem_check_pkg.sv
design/np2_addr_split.sv
design/port_rule_check.sv
design/bit_shadow.sv
design/read_data_check.sv
design/mem_check_top.sv
verification/mem_check_monitor.sv
verification/mem_check_tb.sv

// File: verification/mem_check_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module mem_check_monitor import mem_check_pkg::*; (
  input  logic clk,
  input  logic done,
  input  int   test_idx,
  input  logic err_range,
  input  logic err_conflict,
  input  logic err_rd_vld,
  input  logic err_rd_data,
  input  logic err_bank_data,
  input  logic exp_range,
  input  logic exp_conflict,
  input  logic exp_rd_vld,
  input  logic exp_rd_data,
  input  logic exp_bank_data,
  output int   fail_count,
  output int   check_count
);

  int   cur_test;
  int   test_errs;
  int   test_cycles;
  logic finished;

  function automatic string test_name(input int idx);
    case (idx)
      0: return "range";
      1: return "conflict";
      2: return "logical_data";
      3: return "read_valid";
      4: return "bank_data";
      default: return "reset";
    endcase
  endfunction

  task automatic compare_flag(input string flag, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      fail_count++;
      test_errs++;
      $display("CHECK FAILED test=%s flag=%s expected=%0b actual=%0b at %0t",
               test_name(cur_test), flag, exp, act, $time);
    end
  endtask

  task automatic report_test();
    $display("test %s: %0d cycles, %0d mismatches", test_name(cur_test),
             test_cycles, test_errs);
  endtask

  initial begin
    fail_count  = 0;
    check_count = 0;
    cur_test    = 0;
    test_errs   = 0;
    test_cycles = 0;
    finished    = 1'b0;
  end

  // flags settle after the edge, sample in mid cycle
  always @(negedge clk) begin
    if (done && !finished) begin
      report_test();
      finished = 1'b1;
    end else if (!done) begin
      if (test_idx != cur_test) begin
        report_test();
        cur_test    = test_idx;
        test_errs   = 0;
        test_cycles = 0;
      end
      test_cycles++;
      compare_flag("err_range", exp_range, err_range);
      compare_flag("err_conflict", exp_conflict, err_conflict);
      compare_flag("err_rd_vld", exp_rd_vld, err_rd_vld);
      compare_flag("err_rd_data", exp_rd_data, err_rd_data);
      compare_flag("err_bank_data", exp_bank_data, err_bank_data);
    end
  end

endmodule

`default_nettype wire

// File: verification/mem_check_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_check_tb import mem_check_pkg::*;;

  localparam int SRAM_DELAY = 2;
  localparam int PHASE_LEN  = 200;
  localparam int NUM_TESTS  = 6;
  localparam int TAIL       = SRAM_DELAY + 3;
  localparam int MAX_CYCLES = 4 + NUM_TESTS * PHASE_LEN + 4 + TAIL + 20;

  logic    clk;
  logic    rst;
  logic    write [NUMWRPT];
  addr_t   wr_adr [NUMWRPT];
  word_t   din [NUMWRPT];
  logic    read [NUMRDPT];
  addr_t   rd_adr [NUMRDPT];
  logic    rd_vld [NUMRDPT];
  word_t   rd_dout [NUMRDPT];
  logic    t1_write [NUMVBNK][NUMBWR];
  row_t    t1_wr_row [NUMVBNK][NUMBWR];
  word_t   t1_din [NUMVBNK][NUMBWR];
  logic    t1_read [NUMVBNK][NUMBRD];
  row_t    t1_rd_row [NUMVBNK][NUMBRD];
  word_t   t1_dout [NUMVBNK][NUMBRD];
  addr_t   select_addr;
  bitsel_t select_bit;
  logic    err_range, err_conflict, err_rd_vld, err_rd_data, err_bank_data;
  logic    exp_range, exp_conflict, exp_rd_vld, exp_rd_data, exp_bank_data;

  int          phase;
  logic        wr_en;
  logic        done;
  int          cyc;
  int          cycles;
  int          fail_count;
  int          check_count;
  int unsigned seed_state;
  int          sel_bank;
  int          sel_row;

  // model state, one ring slot per cycle
  logic lsh, linv, bsh, binv;
  logic lsel_r [16][NUMRDPT];
  logic lval_r [16];
  logic linv_r [16];
  logic bsel_r [16][NUMBRD];
  logic bval_r [16];
  logic binv_r [16];

  mem_check_top #(
    .SRAM_DELAY (SRAM_DELAY)
  ) mem_check_top_inst (
    .clk (clk), .rst (rst),
    .write (write), .wr_adr (wr_adr), .din (din),
    .read (read), .rd_adr (rd_adr), .rd_vld (rd_vld), .rd_dout (rd_dout),
    .t1_write (t1_write), .t1_wr_row (t1_wr_row), .t1_din (t1_din),
    .t1_read (t1_read), .t1_rd_row (t1_rd_row), .t1_dout (t1_dout),
    .select_addr (select_addr), .select_bit (select_bit),
    .err_range (err_range), .err_conflict (err_conflict), .err_rd_vld (err_rd_vld),
    .err_rd_data (err_rd_data), .err_bank_data (err_bank_data)
  );

  mem_check_monitor monitor_inst (
    .clk (clk), .done (done), .test_idx (phase),
    .err_range (err_range), .err_conflict (err_conflict), .err_rd_vld (err_rd_vld),
    .err_rd_data (err_rd_data), .err_bank_data (err_bank_data),
    .exp_range (exp_range), .exp_conflict (exp_conflict), .exp_rd_vld (exp_rd_vld),
    .exp_rd_data (exp_rd_data), .exp_bank_data (exp_bank_data),
    .fail_count (fail_count), .check_count (check_count)
  );

  always #50 clk = ~clk;

  function automatic int unsigned rand32();
    int unsigned s;
    s = seed_state;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    seed_state = s;
    return s;
  endfunction

  // favors the tracked address, out of range codes only in the range test
  function automatic addr_t pick_addr();
    int unsigned r;
    r = rand32() % 8;
    if (r < 3) return select_addr;
    if (phase == 0 && r == 3) return addr_t'(NUMADDR + rand32() % 32);
    return addr_t'(rand32() % NUMADDR);
  endfunction

  function automatic row_t pick_row();
    if (rand32() % 4 < 2) return row_t'(sel_row);
    return row_t'(rand32() % NUMVROW);
  endfunction

  function automatic logic corrupt();
    if (!wr_en) return 1'b1;  // shadows invalid, a bad bit must pass
    return (rand32() % ((phase == 2 || phase == 4) ? 3 : 12)) == 0;
  endfunction

  task automatic model_step();
    int   slot;
    int   due;
    logic hit;
    slot = cyc % 16;
    due  = (cyc + 16 - SRAM_DELAY) % 16;
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        for (int p = 0; p < NUMRDPT; p++) lsel_r[i][p] = 1'b0;
        for (int q = 0; q < NUMBRD; q++) bsel_r[i][q] = 1'b0;
      end
      linv = 1'b1;
      binv = 1'b1;
      {exp_range, exp_conflict, exp_rd_vld, exp_rd_data, exp_bank_data} <= '0;
    end else begin
      hit = 1'b0;
      for (int p = 0; p < NUMWRPT; p++) hit |= write[p] && (wr_adr[p] >= NUMADDR);
      for (int p = 0; p < NUMRDPT; p++) hit |= read[p] && (rd_adr[p] >= NUMADDR);
      exp_range <= hit;
      hit = 1'b0;
      for (int b = 0; b < NUMVBNK; b++) begin
        hit |= t1_write[b][0] && t1_write[b][1] && (t1_wr_row[b][0] == t1_wr_row[b][1]);
      end
      exp_conflict <= hit;
      // shadow as seen during this cycle, before its own writes
      lval_r[slot] = lsh;
      linv_r[slot] = linv;
      bval_r[slot] = bsh;
      binv_r[slot] = binv;
      for (int p = 0; p < NUMRDPT; p++) lsel_r[slot][p] = read[p] && (rd_adr[p] == select_addr);
      for (int q = 0; q < NUMBRD; q++) begin
        bsel_r[slot][q] = t1_read[sel_bank][q] && (t1_rd_row[sel_bank][q] == sel_row);
      end
      hit = 1'b0;
      for (int p = 0; p < NUMRDPT; p++) hit |= lsel_r[due][p] && !rd_vld[p];
      exp_rd_vld <= hit;
      hit = 1'b0;
      for (int p = 0; p < NUMRDPT; p++) begin
        hit |= lsel_r[due][p] && !linv_r[due] && (rd_dout[p][select_bit] != lval_r[due]);
      end
      exp_rd_data <= hit;
      hit = 1'b0;
      for (int q = 0; q < NUMBRD; q++) begin
        hit |= bsel_r[due][q] && !binv_r[due] &&
               (t1_dout[sel_bank][q][select_bit] != bval_r[due]);
      end
      exp_bank_data <= hit;
      for (int p = 0; p < NUMWRPT; p++) begin  // higher port wins
        if (write[p] && wr_adr[p] == select_addr) begin
          lsh  = din[p][select_bit];
          linv = 1'b0;
        end
      end
      for (int q = 0; q < NUMBWR; q++) begin
        if (t1_write[sel_bank][q] && t1_wr_row[sel_bank][q] == sel_row) begin
          bsh  = t1_din[sel_bank][q][select_bit];
          binv = 1'b0;
        end
      end
    end
  endtask

  task automatic drive_inputs();
    int    due;
    word_t w;
    row_t  r0;
    due = (cyc + 17 - SRAM_DELAY) % 16;  // response due next cycle
    for (int p = 0; p < NUMWRPT; p++) begin
      write[p]  <= wr_en && (rand32() % 2 == 0);
      wr_adr[p] <= pick_addr();
      din[p]    <= word_t'(rand32());
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      read[p]   <= (rand32() % 2 == 0);
      rd_adr[p] <= pick_addr();
      rd_vld[p] <= (phase == 3) ? (rand32() % 4 != 0) : 1'b1;
      w = word_t'(rand32());
      w[select_bit] = lval_r[due] ^ corrupt();
      rd_dout[p] <= w;
    end
    for (int b = 0; b < NUMVBNK; b++) begin
      r0 = pick_row();
      for (int q = 0; q < NUMBWR; q++) begin
        t1_write[b][q] <= wr_en && (rand32() % 2 == 0);
        t1_din[b][q]   <= word_t'(rand32());
        if (q > 0 && phase == 1 && rand32() % 2 == 0) t1_wr_row[b][q] <= r0;
        else if (q == 0) t1_wr_row[b][q] <= r0;
        else t1_wr_row[b][q] <= pick_row();
      end
      for (int q = 0; q < NUMBRD; q++) begin
        t1_read[b][q]   <= (rand32() % 2 == 0);
        t1_rd_row[b][q] <= pick_row();
        w = word_t'(rand32());
        w[select_bit] = bval_r[due] ^ corrupt();
        t1_dout[b][q] <= w;
      end
    end
  endtask

  always @(posedge clk) begin
    model_step();
    drive_inputs();
    cyc <= cyc + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, test sequence never completed", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    phase = 0;
    wr_en = 1'b1;
    done = 1'b0;
    cyc = 0;
    cycles = 0;
    seed_state = 32'hc7d5ad48;
    select_addr = addr_t'(rand32() % NUMADDR);
    select_bit  = bitsel_t'(rand32());
    sel_bank = select_addr % NUMVBNK;
    sel_row  = select_addr / NUMVBNK;
    lsh = 1'b0;
    bsh = 1'b0;
    for (int p = 0; p < NUMWRPT; p++) begin
      write[p]  = 1'b0;
      wr_adr[p] = '0;
      din[p]    = '0;
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      read[p]    = 1'b0;
      rd_adr[p]  = '0;
      rd_vld[p]  = 1'b1;
      rd_dout[p] = '0;
    end
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int q = 0; q < NUMBWR; q++) begin
        t1_write[b][q]  = 1'b0;
        t1_wr_row[b][q] = '0;
        t1_din[b][q]    = '0;
      end
      for (int q = 0; q < NUMBRD; q++) begin
        t1_read[b][q]   = 1'b0;
        t1_rd_row[b][q] = '0;
        t1_dout[b][q]   = '0;
      end
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      phase <= t;
      if (t == NUM_TESTS - 1) begin
        rst   <= 1'b1;  // reset again mid run
        wr_en <= 1'b0;  // no writes until well after reset
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (12) @(posedge clk);
        wr_en <= 1'b1;
        repeat (PHASE_LEN - 12) @(posedge clk);
      end else begin
        repeat (PHASE_LEN) @(posedge clk);
      end
    end
    repeat (TAIL) @(posedge clk);
    done <= 1'b1;
    @(negedge clk);
    #1;
    $display("checks: %0d, failures: %0d", check_count, fail_count);
    if (fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
